// ==== Bender.yml ====
package:
  name: l1d

sources:
  - hw/l1d_cfg_pkg.sv
  - hw/l1d_lsu_pkg.sv
  - hw/l1d_resp_decode.sv
  - hw/l1d_lrq.sv
  - hw/l1d_data_array.sv
  - hw/l1d_update_merge.sv
  - hw/l1d_top.sv
  - target: test
    files:
      - dv/tb_l1d.sv

// ==== dv/tb_l1d.sv ====
`timescale 1ns/100ps

module tb_l1d;

  localparam int PORTS = 3;
  localparam int ENTRIES = 4;
  localparam int CYCLE_LIMIT = 20000;

  logic         i_clk;
  logic         i_reset_n;
  logic         i_rd_s0_valid [PORTS];
  logic [31:0]  i_rd_s0_paddr [PORTS];
  logic         o_rd_s1_hit [PORTS];
  logic         o_rd_s1_miss [PORTS];
  logic         o_rd_s1_conflict [PORTS];
  logic [127:0] o_rd_s1_data [PORTS];
  logic         i_wr_valid;
  logic [31:0]  i_wr_paddr;
  logic [127:0] i_wr_data;
  logic [15:0]  i_wr_be;
  logic         o_wr_conflict;
  logic         o_l2_req_valid;
  logic [31:0]  o_l2_req_paddr;
  logic [7:0]   o_l2_req_tag;
  logic         i_l2_resp_valid;
  logic [7:0]   i_l2_resp_tag;
  logic [127:0] i_l2_resp_data;

  l1d_top #(.RD_PORT_NUM(PORTS), .LRQ_ENTRY_NUM(ENTRIES)) l1d_top_inst (.*);

  // --------------------------------------------------
  // Reference model state
  // --------------------------------------------------
  logic [23:0]  m_tag [16][2];
  logic [127:0] m_data [16][2];
  logic         m_valid [16][2];
  logic         m_rr [16];
  logic         m_lrq_v [ENTRIES];
  logic [27:0]  m_lrq_line [ENTRIES];
  logic         m_rp1_v, m_rp2_v;
  logic [1:0]   m_rp1_e;
  logic [127:0] m_rp1_d, m_rp2_d;
  logic [31:0]  m_rp2_pa;
  logic         m_miss [PORTS];
  logic [27:0]  m_miss_line [PORTS];
  logic         e_hit [PORTS];
  logic         e_conf [PORTS];
  logic [127:0] e_data [PORTS];
  logic         e_req_v;
  logic [31:0]  e_req_pa;
  logic [7:0]   e_req_tag;

  logic [31:0]  rng = 32'h3bc5_60f8;
  int           cycle = 0;
  int           errors = 0;
  int           n_hit, n_conf, n_req, n_wconf, n_foreign;
  logic [31:0]  q_pa [$];
  logic [7:0]   q_tag [$];
  int           q_due [$];

  initial begin
    i_clk = 1'b0;
    forever #50 i_clk = ~i_clk;
  end

  always @(posedge i_clk) begin
    cycle <= cycle + 1;
    if (cycle >= CYCLE_LIMIT) begin
      $display("Run stopped: cycle limit of %0d reached", CYCLE_LIMIT);
      $display("TEST FAILED");
      $finish;
    end
  end

  function automatic logic [31:0] xorshift(input logic [31:0] s);
    s = s ^ (s << 13);
    s = s ^ (s >> 17);
    s = s ^ (s << 5);
    return s;
  endfunction

  function automatic logic [31:0] rand32();
    rng = xorshift(rng);
    return rng;
  endfunction

  // 8 lines on sets 2, 7 and 11
  function automatic logic [31:0] line_addr(input int i);
    logic [3:0] set;
    set = (i % 3 == 0) ? 4'd2 : (i % 3 == 1) ? 4'd7 : 4'd11;
    return {24'(24'h0a_0000 + i), set, 4'h0};
  endfunction

  function automatic logic [127:0] line_hash(input logic [31:0] pa);
    logic [31:0]  h;
    logic [127:0] d;
    h = pa ^ 32'h5bd1_e995;
    for (int k = 0; k < 4; k++) begin
      h = xorshift(h + 32'h9e37_79b9);
      d[k*32 +: 32] = h;
    end
    return d;
  endfunction

  function automatic void report(input string msg);
    $display("error at %0t ns: %s", $time, msg);
    errors++;
  endfunction

  // --------------------------------------------------
  // Model advance over one clock edge
  // --------------------------------------------------
  task automatic model_step();
    logic         upd_v, upd_ref, busy, pend;
    logic [31:0]  upd_pa, srch;
    logic [127:0] upd_d;
    logic [15:0]  upd_be;
    logic [3:0]   ui, ri;
    int           hw, pick, free, vic;
    upd_ref = m_rp2_v;
    upd_v   = m_rp2_v | i_wr_valid;
    upd_pa  = m_rp2_v ? m_rp2_pa : i_wr_paddr;
    upd_d   = m_rp2_v ? m_rp2_d : i_wr_data;
    upd_be  = m_rp2_v ? 16'hffff : i_wr_be;
    ui      = upd_pa[7:4];
    // LRQ allocation from last cycle's misses
    pick = -1;
    for (int p = 0; p < PORTS; p++) if (m_miss[p] && pick < 0) pick = p;
    pend = 1'b0;
    free = -1;
    for (int e = 0; e < ENTRIES; e++) begin
      if (pick >= 0 && m_lrq_v[e] && m_lrq_line[e] == m_miss_line[pick]) pend = 1'b1;
      if (!m_lrq_v[e] && free < 0) free = e;
    end
    e_req_v = (pick >= 0) && !pend && (free >= 0);
    srch = {m_lrq_line[m_rp1_e], 4'h0};
    if (m_rp1_v) begin
      if (!m_lrq_v[m_rp1_e]) report("refill names a free LRQ entry");
      m_lrq_v[m_rp1_e] = 1'b0;
    end
    if (e_req_v) begin
      e_req_pa  = {m_miss_line[pick], 4'h0};
      e_req_tag = {2'b10, 4'b0000, 2'(free)};
      m_lrq_v[free]    = 1'b1;
      m_lrq_line[free] = m_miss_line[pick];
    end
    // Reads see the array before this edge's update
    for (int p = 0; p < PORTS; p++) begin
      ri = i_rd_s0_paddr[p][7:4];
      hw = -1;
      for (int w = 0; w < 2; w++) begin
        if (m_valid[ri][w] && m_tag[ri][w] == i_rd_s0_paddr[p][31:8]) hw = w;
      end
      busy           = upd_v && (ui == ri);
      e_hit[p]       = i_rd_s0_valid[p] && !busy && hw >= 0;
      m_miss[p]      = i_rd_s0_valid[p] && !busy && hw < 0;
      e_conf[p]      = i_rd_s0_valid[p] && busy;
      e_data[p]      = (hw >= 0) ? m_data[ri][hw] : '0;
      m_miss_line[p] = i_rd_s0_paddr[p][31:4];
    end
    if (upd_v) begin
      hw = -1;
      for (int w = 0; w < 2; w++) begin
        if (m_valid[ui][w] && m_tag[ui][w] == upd_pa[31:8]) hw = w;
      end
      if (hw >= 0) begin
        for (int b = 0; b < 16; b++) begin
          if (upd_be[b]) m_data[ui][hw][b*8 +: 8] = upd_d[b*8 +: 8];
        end
      end else if (upd_ref) begin
        vic = m_rr[ui];
        if (!m_valid[ui][1]) vic = 1;
        if (!m_valid[ui][0]) vic = 0;
        m_valid[ui][vic] = 1'b1;
        m_tag[ui][vic]   = upd_pa[31:8];
        m_data[ui][vic]  = upd_d;
      end
      if (upd_ref) m_rr[ui] = ~m_rr[ui];
    end
    m_rp2_v  = m_rp1_v;
    m_rp2_pa = srch;
    m_rp2_d  = m_rp1_d;
    m_rp1_v  = i_l2_resp_valid && i_l2_resp_tag[7:6] == 2'b10;
    m_rp1_e  = i_l2_resp_tag[1:0];
    m_rp1_d  = i_l2_resp_data;
  endtask

  task automatic compare_outputs();
    for (int p = 0; p < PORTS; p++) begin
      if (o_rd_s1_hit[p] !== e_hit[p] || o_rd_s1_miss[p] !== m_miss[p] ||
          o_rd_s1_conflict[p] !== e_conf[p]) begin
        report($sformatf("port %0d status h/m/c %b%b%b, expected %b%b%b", p, o_rd_s1_hit[p],
               o_rd_s1_miss[p], o_rd_s1_conflict[p], e_hit[p], m_miss[p], e_conf[p]));
      end else if (e_hit[p] && o_rd_s1_data[p] !== e_data[p]) begin
        report($sformatf("port %0d data %h, expected %h", p, o_rd_s1_data[p], e_data[p]));
      end
      n_hit  += e_hit[p];
      n_conf += e_conf[p];
    end
    if (o_l2_req_valid !== e_req_v) begin
      report($sformatf("L2 request valid %b, expected %b", o_l2_req_valid, e_req_v));
    end else if (e_req_v && (o_l2_req_paddr !== e_req_pa || o_l2_req_tag !== e_req_tag)) begin
      report($sformatf("L2 request %h tag %h, expected %h tag %h", o_l2_req_paddr,
             o_l2_req_tag, e_req_pa, e_req_tag));
    end
  endtask

  // --------------------------------------------------
  // Stimulus and L2 responder
  // --------------------------------------------------
  task automatic drive_inputs(input int mode);
    logic [31:0] r;
    int          sel;
    for (int p = 0; p < PORTS; p++) begin
      r = rand32();
      sel = (mode == 0) ? (r[9:8] % 3) : r[10:8];
      case (mode)
        0:       i_rd_s0_valid[p] = (p == 0) && r[1:0] == 2'b00;
        1:       i_rd_s0_valid[p] = (p < 2) && r[0];
        2, 4:    i_rd_s0_valid[p] = r[0];
        default: i_rd_s0_valid[p] = 1'b1;
      endcase
      i_rd_s0_paddr[p] = line_addr(sel) | r[15:12];
    end
    r = rand32();
    i_wr_valid = (mode == 3) || (mode == 2 && r[0]);
    i_wr_paddr = line_addr(r[10:8]) | r[15:12];
    i_wr_be    = r[31:16];
    i_wr_data  = {rand32(), rand32(), rand32(), rand32()};
    if (o_l2_req_valid) begin
      q_pa.push_back(o_l2_req_paddr);
      q_tag.push_back(o_l2_req_tag);
      q_due.push_back(cycle + 2 + rand32() % 8);
    end
    i_l2_resp_valid = 1'b0;
    for (int i = 0; i < q_due.size(); i++) begin
      if (!i_l2_resp_valid && q_due[i] <= cycle) begin
        i_l2_resp_valid = 1'b1;
        i_l2_resp_tag   = q_tag[i];
        i_l2_resp_data  = line_hash(q_pa[i]);
        q_pa.delete(i);
        q_tag.delete(i);
        q_due.delete(i);
      end
    end
    r = rand32();
    if (!i_l2_resp_valid && mode == 4 && r[1:0] == 2'b00) begin
      i_l2_resp_valid = 1'b1;
      i_l2_resp_tag   = {(r[3:2] == 2'b10) ? 2'b11 : r[3:2], 4'b0000, r[5:4]};  // Not 2'b10
      i_l2_resp_data  = {4{r}};
      n_foreign++;
    end
  endtask

  task automatic run_test(input string name, input int mode, input int cycles);
    int    err0;
    string summary;
    err0 = errors;
    n_hit = 0;
    n_conf = 0;
    n_req = 0;
    n_wconf = 0;
    n_foreign = 0;
    repeat (cycles) begin
      @(negedge i_clk);
      model_step();
      compare_outputs();
      n_req += e_req_v;
      drive_inputs(mode);
      #1;
      if (o_wr_conflict !== (m_rp2_v & i_wr_valid)) begin
        report($sformatf("store conflict %b, expected %b", o_wr_conflict, m_rp2_v & i_wr_valid));
      end
      n_wconf += (m_rp2_v & i_wr_valid);
    end
    summary = $sformatf("%s %0d errors, %0d hits, %0d read conflicts,", name, errors - err0,
                        n_hit, n_conf);
    $display("%s %0d requests, %0d store conflicts, %0d foreign", summary, n_req, n_wconf,
             n_foreign);
  endtask

  initial begin
    i_reset_n = 1'b0;
    i_wr_valid = 1'b0;
    i_wr_paddr = '0;
    i_wr_data = '0;
    i_wr_be = '0;
    i_l2_resp_valid = 1'b0;
    i_l2_resp_tag = '0;
    i_l2_resp_data = '0;
    for (int p = 0; p < PORTS; p++) begin
      i_rd_s0_valid[p] = 1'b0;
      i_rd_s0_paddr[p] = '0;
      m_miss[p] = 1'b0;
      m_miss_line[p] = '0;
    end
    for (int s = 0; s < 16; s++) begin
      m_rr[s] = 1'b0;
      for (int w = 0; w < 2; w++) m_valid[s][w] = 1'b0;
    end
    for (int e = 0; e < ENTRIES; e++) begin
      m_lrq_v[e] = 1'b0;
      m_lrq_line[e] = '0;
    end
    m_rp1_v = 1'b0;
    m_rp1_e = '0;
    m_rp2_v = 1'b0;
    repeat (5) @(posedge i_clk);
    @(negedge i_clk);
    i_reset_n = 1'b1;
    run_test("cold_read", 0, 400);
    run_test("refill", 1, 500);
    run_test("stores", 2, 500);
    run_test("collision", 3, 500);
    run_test("foreign", 4, 500);
    run_test("parallel", 5, 600);
    $display("Summary: 6 tests, %0d errors, %0d cycles", errors, cycle);
    if (errors == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

// ==== files.f ====
hw/l1d_cfg_pkg.sv
hw/l1d_lsu_pkg.sv
hw/l1d_resp_decode.sv
hw/l1d_lrq.sv
hw/l1d_data_array.sv
hw/l1d_update_merge.sv
hw/l1d_top.sv
dv/tb_l1d.sv

// ==== hw/l1d_cfg_pkg.sv ====
package l1d_cfg_pkg;

  // --------------------------------------------------
  // Physical address
  // --------------------------------------------------
  localparam int PADDR_W = 32;

  // --------------------------------------------------
  // Line geometry
  // --------------------------------------------------
  localparam int LINE_BYTES = 16;           // Bytes per cache line
  localparam int DATA_W     = LINE_BYTES * 8;  // Full line as one word

  // --------------------------------------------------
  // Array organization
  // --------------------------------------------------
  // Two-way set associative, small enough to fill quickly
  localparam int SET_NUM = 16;
  localparam int WAY_NUM = 2;

endpackage

// ==== hw/l1d_data_array.sv ====
`timescale 1ns/100ps

module l1d_data_array
  import l1d_cfg_pkg::*;
  import l1d_lsu_pkg::*;
#(
  parameter int RD_PORT_NUM = 3
) (
  input  logic               i_clk,
  input  logic               i_reset_n,

  // Read ports, s0 in and s1 out
  input  logic               i_rd_valid    [RD_PORT_NUM],
  input  logic [PADDR_W-1:0] i_rd_paddr    [RD_PORT_NUM],
  output logic               o_rd_hit      [RD_PORT_NUM],
  output logic               o_rd_miss     [RD_PORT_NUM],
  output logic               o_rd_conflict [RD_PORT_NUM],
  output logic [DATA_W-1:0]  o_rd_data     [RD_PORT_NUM],

  // Update port, refill or store
  input  logic               i_upd_valid,
  input  logic [PADDR_W-1:0] i_upd_paddr,
  input  logic [DATA_W-1:0]  i_upd_data,
  input  logic [BE_W-1:0]    i_upd_be,
  input  logic               i_upd_refill,

  // Miss report to the LRQ
  output logic               o_miss_valid  [RD_PORT_NUM],
  output logic [PADDR_W-1:0] o_miss_paddr  [RD_PORT_NUM]
);

  localparam int WAY_W = $clog2(WAY_NUM);

  logic [TAG_W-1:0]                  r_tag  [SET_NUM][WAY_NUM];
  logic [DATA_W-1:0]                 r_data [SET_NUM][WAY_NUM];
  logic [SET_NUM-1:0][WAY_NUM-1:0]   r_valid;
  logic [SET_NUM-1:0][WAY_W-1:0]     r_rr;   // Round-robin pointer per set

  logic [INDEX_W-1:0] w_upd_idx;
  logic [TAG_W-1:0]   w_upd_tag;
  logic [WAY_NUM-1:0] w_upd_way_hit;
  logic               w_upd_hit;
  logic [WAY_W-1:0]   w_victim;

  // --------------------------------------------------
  // Read ports
  // --------------------------------------------------
  for (genvar p = 0; p < RD_PORT_NUM; p++) begin : g_port
    logic [INDEX_W-1:0]        w_idx;
    logic [TAG_W-1:0]          w_tag;
    logic [WAY_NUM-1:0]        w_way_hit;
    logic                      w_set_busy;
    logic [DATA_W-1:0]         w_data;
    logic [PADDR_W-OFFSET_W-1:0] r_line;

    assign w_idx      = i_rd_paddr[p][OFFSET_W +: INDEX_W];
    assign w_tag      = i_rd_paddr[p][PADDR_W-1 -: TAG_W];
    assign w_set_busy = i_upd_valid & (w_upd_idx == w_idx);  // Retry needed

    always_comb begin
      w_data = '0;
      for (int w = 0; w < WAY_NUM; w++) begin
        w_way_hit[w] = r_valid[w_idx][w] & (r_tag[w_idx][w] == w_tag);
        if (w_way_hit[w]) w_data = r_data[w_idx][w];
      end
    end

    always_ff @(posedge i_clk or negedge i_reset_n) begin
      if (!i_reset_n) begin
        o_rd_hit[p]      <= 1'b0;
        o_rd_miss[p]     <= 1'b0;
        o_rd_conflict[p] <= 1'b0;
      end else begin
        o_rd_hit[p]      <= i_rd_valid[p] & ~w_set_busy & (|w_way_hit);
        o_rd_miss[p]     <= i_rd_valid[p] & ~w_set_busy & ~(|w_way_hit);
        o_rd_conflict[p] <= i_rd_valid[p] & w_set_busy;
      end
    end

    always_ff @(posedge i_clk) begin
      o_rd_data[p] <= w_data;
      r_line       <= i_rd_paddr[p][PADDR_W-1:OFFSET_W];
    end

    assign o_miss_valid[p] = o_rd_miss[p];
    assign o_miss_paddr[p] = {r_line, {OFFSET_W{1'b0}}};
  end

  // --------------------------------------------------
  // Update port
  // --------------------------------------------------
  assign w_upd_idx = i_upd_paddr[OFFSET_W +: INDEX_W];
  assign w_upd_tag = i_upd_paddr[PADDR_W-1 -: TAG_W];
  assign w_upd_hit = |w_upd_way_hit;

  always_comb begin
    w_victim = r_rr[w_upd_idx];
    for (int w = WAY_NUM - 1; w >= 0; w--) begin
      w_upd_way_hit[w] = r_valid[w_upd_idx][w] & (r_tag[w_upd_idx][w] == w_upd_tag);
      if (!r_valid[w_upd_idx][w]) w_victim = WAY_W'(w);  // Lowest invalid way first
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_upd_valid) begin
      for (int w = 0; w < WAY_NUM; w++) begin
        if (w_upd_way_hit[w]) begin
          for (int b = 0; b < BE_W; b++) begin
            if (i_upd_be[b]) r_data[w_upd_idx][w][b*8 +: 8] <= i_upd_data[b*8 +: 8];
          end
        end else if (i_upd_refill && !w_upd_hit && w_victim == WAY_W'(w)) begin
          r_tag[w_upd_idx][w]  <= w_upd_tag;
          r_data[w_upd_idx][w] <= i_upd_data;
        end
      end
    end
  end

  // Pointer advances on every refill into the set, hit or fill
  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_valid <= '0;
      r_rr    <= '0;
    end else if (i_upd_valid && i_upd_refill) begin
      if (!w_upd_hit) r_valid[w_upd_idx][w_victim] <= 1'b1;
      r_rr[w_upd_idx] <= r_rr[w_upd_idx] + 1'b1;
    end
  end

  a_refill_full_be : assert property (@(posedge i_clk) disable iff (!i_reset_n)
    (i_upd_valid && i_upd_refill) |-> (&i_upd_be));

endmodule

// ==== hw/l1d_lrq.sv ====
`timescale 1ns/100ps

module l1d_lrq
  import l1d_cfg_pkg::*;
  import l1d_lsu_pkg::*;
#(
  parameter  int RD_PORT_NUM   = 3,
  parameter  int LRQ_ENTRY_NUM = 4,
  localparam int ENTRY_W       = $clog2(LRQ_ENTRY_NUM)
) (
  input  logic                    i_clk,
  input  logic                    i_reset_n,

  // Miss reports from the array
  input  logic                    i_miss_valid [RD_PORT_NUM],
  input  logic [PADDR_W-1:0]      i_miss_paddr [RD_PORT_NUM],

  // Search from refill stage 1
  input  logic                    i_search_valid,
  input  logic [ENTRY_W-1:0]      i_search_entry,
  output logic [PADDR_W-1:0]      o_search_paddr,

  // L2 read request
  output logic                    o_l2_req_valid,
  output logic [PADDR_W-1:0]      o_l2_req_paddr,
  output logic [L2_CMD_TAG_W-1:0] o_l2_req_tag
);

  localparam int LINE_W = PADDR_W - OFFSET_W;

  logic [LRQ_ENTRY_NUM-1:0] r_entry_valid;
  logic [LINE_W-1:0]        r_entry_line [LRQ_ENTRY_NUM];

  logic                     w_pick_valid;
  logic [LINE_W-1:0]        w_pick_line;
  logic                     w_pending;
  logic [ENTRY_W-1:0]       w_free_idx;
  logic                     w_alloc;
  logic [LRQ_ENTRY_NUM-1:0] w_set_mask;
  logic [LRQ_ENTRY_NUM-1:0] w_clr_mask;
  logic [L2_CMD_TAG_W-1:0]  w_req_tag;

  // --------------------------------------------------
  // Allocation
  // --------------------------------------------------
  always_comb begin
    w_pick_valid = 1'b0;
    w_pick_line  = '0;
    for (int p = RD_PORT_NUM - 1; p >= 0; p--) begin  // Lowest port wins
      if (i_miss_valid[p]) begin
        w_pick_valid = 1'b1;
        w_pick_line  = i_miss_paddr[p][PADDR_W-1:OFFSET_W];
      end
    end
  end

  always_comb begin
    w_pending  = 1'b0;
    w_free_idx = '0;
    for (int e = LRQ_ENTRY_NUM - 1; e >= 0; e--) begin
      if (r_entry_valid[e] && r_entry_line[e] == w_pick_line) w_pending = 1'b1;
      if (!r_entry_valid[e]) w_free_idx = ENTRY_W'(e);
    end
  end

  // Same line in flight or queue full, the pipeline will retry
  assign w_alloc = w_pick_valid & ~w_pending & ~(&r_entry_valid);

  assign w_set_mask = w_alloc ? (LRQ_ENTRY_NUM'(1) << w_free_idx) : '0;
  assign w_clr_mask = i_search_valid ? (LRQ_ENTRY_NUM'(1) << i_search_entry) : '0;

  always_comb begin
    w_req_tag                         = '0;
    w_req_tag[L2_CMD_TAG_W-1 -: 2]    = L2_UPPER_TAG_RD_L1D;
    w_req_tag[ENTRY_W-1:0]            = w_free_idx;
  end

  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_entry_valid  <= '0;
      o_l2_req_valid <= 1'b0;
    end else begin
      r_entry_valid  <= (r_entry_valid & ~w_clr_mask) | w_set_mask;
      o_l2_req_valid <= w_alloc;  // One-cycle pulse
    end
  end

  always_ff @(posedge i_clk) begin
    if (w_alloc) begin
      r_entry_line[w_free_idx] <= w_pick_line;
      o_l2_req_paddr           <= {w_pick_line, {OFFSET_W{1'b0}}};
      o_l2_req_tag             <= w_req_tag;
    end
  end

  // --------------------------------------------------
  // Search, freed at the next edge
  // --------------------------------------------------
  assign o_search_paddr = {r_entry_line[i_search_entry], {OFFSET_W{1'b0}}};

  a_search_valid_entry : assert property (@(posedge i_clk) disable iff (!i_reset_n)
    i_search_valid |-> r_entry_valid[i_search_entry]);

  for (genvar a = 0; a < LRQ_ENTRY_NUM; a++) begin : g_dup_a
    for (genvar b = a + 1; b < LRQ_ENTRY_NUM; b++) begin : g_dup_b
      a_no_dup_line : assert property (@(posedge i_clk) disable iff (!i_reset_n)
        !(r_entry_valid[a] && r_entry_valid[b] && r_entry_line[a] == r_entry_line[b]));
    end
  end

endmodule

// ==== hw/l1d_lsu_pkg.sv ====
package l1d_lsu_pkg;

  import l1d_cfg_pkg::*;

  // --------------------------------------------------
  // Address split
  // --------------------------------------------------
  // | tag | index | offset |
  localparam int OFFSET_W = $clog2(LINE_BYTES);
  localparam int INDEX_W  = $clog2(SET_NUM);
  localparam int TAG_W    = PADDR_W - INDEX_W - OFFSET_W;

  // One enable per byte of the line
  localparam int BE_W = LINE_BYTES;

  // --------------------------------------------------
  // L2 command tag
  // --------------------------------------------------
  // Top two bits give the requester class, LRQ entry sits in the low bits
  localparam int L2_CMD_TAG_W = 8;

  localparam logic [1:0] L2_UPPER_TAG_RD_L1D = 2'd2;  // L1D line read

endpackage

// ==== hw/l1d_resp_decode.sv ====
`timescale 1ns/100ps

module l1d_resp_decode
  import l1d_cfg_pkg::*;
  import l1d_lsu_pkg::*;
#(
  parameter  int LRQ_ENTRY_NUM = 4,
  localparam int ENTRY_W       = $clog2(LRQ_ENTRY_NUM)
) (
  input  logic                    i_clk,
  input  logic                    i_reset_n,

  // L2 response
  input  logic                    i_l2_resp_valid,
  input  logic [L2_CMD_TAG_W-1:0] i_l2_resp_tag,
  input  logic [DATA_W-1:0]       i_l2_resp_data,

  // Refill stage 1
  output logic                    o_rp1_valid,
  output logic [ENTRY_W-1:0]      o_rp1_entry,
  output logic [DATA_W-1:0]       o_rp1_data
);

  logic w_is_l1d;

  // Only responses to our own read requests go on
  assign w_is_l1d = (i_l2_resp_tag[L2_CMD_TAG_W-1 -: 2] == L2_UPPER_TAG_RD_L1D);

  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      o_rp1_valid <= 1'b0;
    end else begin
      o_rp1_valid <= i_l2_resp_valid & w_is_l1d;
    end
  end

  always_ff @(posedge i_clk) begin
    o_rp1_entry <= i_l2_resp_tag[ENTRY_W-1:0];  // Entry number from low bits
    o_rp1_data  <= i_l2_resp_data;
  end

  // L2 must echo a tag that the LRQ actually handed out
  a_entry_in_range : assert property (@(posedge i_clk) disable iff (!i_reset_n)
    (i_l2_resp_valid && w_is_l1d) |-> (int'(i_l2_resp_tag[L2_CMD_TAG_W-3:0]) < LRQ_ENTRY_NUM));

endmodule

// ==== hw/l1d_top.sv ====
`timescale 1ns/100ps

module l1d_top
  import l1d_cfg_pkg::*;
  import l1d_lsu_pkg::*;
#(
  parameter int RD_PORT_NUM   = 3,
  parameter int LRQ_ENTRY_NUM = 4
) (
  input  logic                    i_clk,
  input  logic                    i_reset_n,

  // Pipeline read ports
  input  logic                    i_rd_s0_valid    [RD_PORT_NUM],
  input  logic [PADDR_W-1:0]      i_rd_s0_paddr    [RD_PORT_NUM],
  output logic                    o_rd_s1_hit      [RD_PORT_NUM],
  output logic                    o_rd_s1_miss     [RD_PORT_NUM],
  output logic                    o_rd_s1_conflict [RD_PORT_NUM],
  output logic [DATA_W-1:0]       o_rd_s1_data     [RD_PORT_NUM],

  // Store port
  input  logic                    i_wr_valid,
  input  logic [PADDR_W-1:0]      i_wr_paddr,
  input  logic [DATA_W-1:0]       i_wr_data,
  input  logic [BE_W-1:0]         i_wr_be,
  output logic                    o_wr_conflict,

  // L2 request and response
  output logic                    o_l2_req_valid,
  output logic [PADDR_W-1:0]      o_l2_req_paddr,
  output logic [L2_CMD_TAG_W-1:0] o_l2_req_tag,
  input  logic                    i_l2_resp_valid,
  input  logic [L2_CMD_TAG_W-1:0] i_l2_resp_tag,
  input  logic [DATA_W-1:0]       i_l2_resp_data
);

  localparam int ENTRY_W = $clog2(LRQ_ENTRY_NUM);

  logic               w_miss_valid [RD_PORT_NUM];
  logic [PADDR_W-1:0] w_miss_paddr [RD_PORT_NUM];

  logic               w_rp1_valid;
  logic [ENTRY_W-1:0] w_rp1_entry;
  logic [DATA_W-1:0]  w_rp1_data;
  logic [PADDR_W-1:0] w_search_paddr;

  logic               w_upd_valid;
  logic [PADDR_W-1:0] w_upd_paddr;
  logic [DATA_W-1:0]  w_upd_data;
  logic [BE_W-1:0]    w_upd_be;
  logic               w_upd_refill;

  l1d_resp_decode #(
    .LRQ_ENTRY_NUM (LRQ_ENTRY_NUM)
  ) u_resp_decode (
    .i_clk           (i_clk),
    .i_reset_n       (i_reset_n),
    .i_l2_resp_valid (i_l2_resp_valid),
    .i_l2_resp_tag   (i_l2_resp_tag),
    .i_l2_resp_data  (i_l2_resp_data),
    .o_rp1_valid     (w_rp1_valid),
    .o_rp1_entry     (w_rp1_entry),
    .o_rp1_data      (w_rp1_data)
  );

  l1d_lrq #(
    .RD_PORT_NUM   (RD_PORT_NUM),
    .LRQ_ENTRY_NUM (LRQ_ENTRY_NUM)
  ) u_lrq (
    .i_clk          (i_clk),
    .i_reset_n      (i_reset_n),
    .i_miss_valid   (w_miss_valid),
    .i_miss_paddr   (w_miss_paddr),
    .i_search_valid (w_rp1_valid),
    .i_search_entry (w_rp1_entry),
    .o_search_paddr (w_search_paddr),
    .o_l2_req_valid (o_l2_req_valid),
    .o_l2_req_paddr (o_l2_req_paddr),
    .o_l2_req_tag   (o_l2_req_tag)
  );

  l1d_data_array #(
    .RD_PORT_NUM (RD_PORT_NUM)
  ) u_data_array (
    .i_clk         (i_clk),
    .i_reset_n     (i_reset_n),
    .i_rd_valid    (i_rd_s0_valid),
    .i_rd_paddr    (i_rd_s0_paddr),
    .o_rd_hit      (o_rd_s1_hit),
    .o_rd_miss     (o_rd_s1_miss),
    .o_rd_conflict (o_rd_s1_conflict),
    .o_rd_data     (o_rd_s1_data),
    .i_upd_valid   (w_upd_valid),
    .i_upd_paddr   (w_upd_paddr),
    .i_upd_data    (w_upd_data),
    .i_upd_be      (w_upd_be),
    .i_upd_refill  (w_upd_refill),
    .o_miss_valid  (w_miss_valid),
    .o_miss_paddr  (w_miss_paddr)
  );

  l1d_update_merge u_update_merge (
    .i_clk          (i_clk),
    .i_reset_n      (i_reset_n),
    .i_rp1_valid    (w_rp1_valid),
    .i_rp1_data     (w_rp1_data),
    .i_search_paddr (w_search_paddr),
    .i_wr_valid     (i_wr_valid),
    .i_wr_paddr     (i_wr_paddr),
    .i_wr_data      (i_wr_data),
    .i_wr_be        (i_wr_be),
    .o_upd_valid    (w_upd_valid),
    .o_upd_paddr    (w_upd_paddr),
    .o_upd_data     (w_upd_data),
    .o_upd_be       (w_upd_be),
    .o_upd_refill   (w_upd_refill),
    .o_wr_conflict  (o_wr_conflict)
  );

endmodule

// ==== hw/l1d_update_merge.sv ====
`timescale 1ns/100ps

module l1d_update_merge
  import l1d_cfg_pkg::*;
  import l1d_lsu_pkg::*;
(
  input  logic               i_clk,
  input  logic               i_reset_n,

  // Refill stage 1 and LRQ search result
  input  logic               i_rp1_valid,
  input  logic [DATA_W-1:0]  i_rp1_data,
  input  logic [PADDR_W-1:0] i_search_paddr,

  // Store from the pipeline
  input  logic               i_wr_valid,
  input  logic [PADDR_W-1:0] i_wr_paddr,
  input  logic [DATA_W-1:0]  i_wr_data,
  input  logic [BE_W-1:0]    i_wr_be,

  // Array update
  output logic               o_upd_valid,
  output logic [PADDR_W-1:0] o_upd_paddr,
  output logic [DATA_W-1:0]  o_upd_data,
  output logic [BE_W-1:0]    o_upd_be,
  output logic               o_upd_refill,
  output logic               o_wr_conflict
);

  logic               r_rp2_valid;
  logic [PADDR_W-1:0] r_rp2_paddr;
  logic [DATA_W-1:0]  r_rp2_data;

  // --------------------------------------------------
  // Refill stage 2
  // --------------------------------------------------
  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_rp2_valid <= 1'b0;
    end else begin
      r_rp2_valid <= i_rp1_valid;
    end
  end

  always_ff @(posedge i_clk) begin
    r_rp2_paddr <= i_search_paddr;  // Line address recovered from LRQ
    r_rp2_data  <= i_rp1_data;
  end

  // Refill has priority, the store is dropped
  assign o_upd_valid   = r_rp2_valid | i_wr_valid;
  assign o_upd_refill  = r_rp2_valid;
  assign o_upd_paddr   = r_rp2_valid ? r_rp2_paddr : i_wr_paddr;
  assign o_upd_data    = r_rp2_valid ? r_rp2_data : i_wr_data;
  assign o_upd_be      = r_rp2_valid ? {BE_W{1'b1}} : i_wr_be;
  assign o_wr_conflict = r_rp2_valid & i_wr_valid;

endmodule
